/* src/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  // ------------------------------------------------------------
  // Pixel and word geometry
  // ------------------------------------------------------------
  localparam int PIX_BITS     = 12;
  localparam int SLOT_BITS    = 16;
  localparam int PIX_PER_WORD = 4;
  localparam int WORD_BITS    = 64;

  typedef logic [SLOT_BITS-1:0] pix_slot_t;

  // Same 64-bit word seen as one raw value or as four pixel slots
  typedef union packed {
    logic [WORD_BITS-1:0]             raw;
    pix_slot_t [PIX_PER_WORD-1:0]     slots;
  } pix_word_u;

  // ------------------------------------------------------------
  // Host register map
  // ------------------------------------------------------------
  localparam int AXIL_ADDR_BITS = 4;
  localparam int AXIL_DATA_BITS = 32;

  localparam logic [AXIL_ADDR_BITS-1:0] REG_CONTROL = 4'h0;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_STATUS  = 4'h4;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_DATA_LO = 4'h8;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_DATA_HI = 4'hC;

  localparam int CTRL_CAPTURE_EN   = 0;
  localparam int CTRL_FIFO_CLEAR   = 1;
  localparam int CTRL_SENSOR_RESET = 2;

  localparam int STAT_COUNT_LSB   = 0;
  localparam int STAT_COUNT_BITS  = 16;
  localparam int STAT_DATA_READY  = 16;
  localparam int STAT_OVERFLOW    = 17;
  localparam int STAT_FRAMES_LSB  = 24;
  localparam int STAT_FRAMES_BITS = 8;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* src/pixel_stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Pixel stream from capture to packer, no back-pressure
interface pixel_stream_if;

  logic                         valid;
  logic [cam_pkg::PIX_BITS-1:0] pixel;
  logic                         sof;
  logic                         eof;

  modport source (
    output valid,
    output pixel,
    output sof,
    output eof
  );

  modport sink (
    input valid,
    input pixel,
    input sof,
    input eof
  );

endinterface

`default_nettype wire

/* src/pixel_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_capture (
  input  wire logic                         pix_clk,
  input  wire logic                         rst_n,
  input  wire logic                         frame_valid,
  input  wire logic                         line_valid,
  input  wire logic [cam_pkg::PIX_BITS-1:0] pix_data,
  input  wire logic                         capture_en,
  pixel_stream_if.source                    out
);

  logic                         fv_q;
  logic                         lv_q;
  logic                         fv_prev;
  logic [cam_pkg::PIX_BITS-1:0] pix_q;
  logic                         active;
  logic                         first_pend;
  logic                         frame_rise;
  logic                         frame_fall;
  logic                         in_frame;

  // ------------------------------------------------------------
  // Sensor bus input register
  // ------------------------------------------------------------
  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      fv_q    <= 1'b0;
      lv_q    <= 1'b0;
      fv_prev <= 1'b0;
    end else begin
      fv_q    <= frame_valid;
      lv_q    <= line_valid;
      fv_prev <= fv_q;
    end
  end

  always_ff @(posedge pix_clk) begin
    pix_q <= pix_data;
  end

  assign frame_rise = fv_q & ~fv_prev;
  assign frame_fall = ~fv_q & fv_prev;

  // Enable is only looked at on the frame's rising edge
  assign in_frame = frame_rise ? capture_en : active;

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      active     <= 1'b0;
      first_pend <= 1'b0;
    end else if (frame_fall) begin
      active     <= 1'b0;
      first_pend <= 1'b0;
    end else begin
      active     <= in_frame;
      first_pend <= (frame_rise ? capture_en : first_pend) & ~out.valid;
    end
  end

  assign out.valid = fv_q & lv_q & in_frame;
  assign out.pixel = pix_q;
  assign out.sof   = out.valid & (frame_rise | first_pend);
  assign out.eof   = frame_fall & active;

endmodule

`default_nettype wire

/* src/pixel_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_packer (
  input  wire logic          pix_clk,
  input  wire logic          rst_n,
  pixel_stream_if.sink       in,
  output logic               word_valid,
  output cam_pkg::pix_word_u word,
  output logic               frame_end
);

  localparam logic [1:0] LAST_SLOT = 2'(cam_pkg::PIX_PER_WORD - 1);

  logic [1:0]         idx;
  logic [1:0]         slot;
  cam_pkg::pix_word_u acc;
  cam_pkg::pix_word_u fill;

  // ------------------------------------------------------------
  // Slot fill
  // ------------------------------------------------------------
  // A new frame restarts at slot 0 with an empty word
  always_comb begin
    slot = in.sof ? 2'd0 : idx;
    fill = in.sof ? '0 : acc;
    fill.slots[slot] = cam_pkg::pix_slot_t'(in.pixel);
  end

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      idx        <= 2'd0;
      word_valid <= 1'b0;
      frame_end  <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      frame_end  <= 1'b0;
      if (in.valid) begin
        if (slot == LAST_SLOT) begin
          word_valid <= 1'b1;
          idx        <= 2'd0;
        end else begin
          idx <= slot + 2'd1;
        end
      end else if (in.eof) begin
        // Flush a partly filled word
        if (idx != 2'd0) begin
          word_valid <= 1'b1;
        end
        idx       <= 2'd0;
        frame_end <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Word payload
  // ------------------------------------------------------------
  // acc is zeroed after every issue so unused slots read as zero
  always_ff @(posedge pix_clk) begin
    if (in.valid) begin
      if (slot == LAST_SLOT) begin
        word <= fill;
        acc  <= '0;
      end else begin
        acc <= fill;
      end
    end else if (in.eof) begin
      word <= acc;
      acc  <= '0;
    end
  end

endmodule

`default_nettype wire

/* src/frame_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_fifo #(
  parameter int FIFO_DEPTH      = 512,
  parameter int READY_THRESHOLD = 256
) (
  input  wire logic                                pix_clk,
  input  wire logic                                rst_n,
  input  wire logic                                word_valid,
  input  wire cam_pkg::pix_word_u                  word,
  input  wire logic                                pop,
  input  wire logic                                clear,
  output logic [cam_pkg::WORD_BITS-1:0]            head,
  output logic [cam_pkg::STAT_COUNT_BITS-1:0]      count,
  output logic                                     data_ready,
  output logic                                     overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = cam_pkg::STAT_COUNT_BITS;
  localparam logic [CW-1:0] FULL_LVL  = CW'(FIFO_DEPTH);
  localparam logic [CW-1:0] READY_LVL = CW'(READY_THRESHOLD);

  logic [cam_pkg::WORD_BITS-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]                 wr_ptr;
  logic [AW-1:0]                 rd_ptr;
  logic                          full;
  logic                          empty;
  logic                          do_wr;
  logic                          do_rd;

  assign full  = (count == FULL_LVL);
  assign empty = (count == '0);
  assign do_wr = word_valid & ~full;
  assign do_rd = pop & ~empty;

  // ------------------------------------------------------------
  // Pointers, count and flags
  // ------------------------------------------------------------
  always_ff @(posedge pix_clk) begin
    if (!rst_n || clear) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until the host clears the buffer
      if (word_valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      data_ready <= 1'b0;
    end else begin
      data_ready <= (count > READY_LVL);
    end
  end

  always_ff @(posedge pix_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= word.raw;
    end
  end

  assign head = mem[rd_ptr];

endmodule

`default_nettype wire

/* src/axil_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
  input  wire logic                                pix_clk,
  input  wire logic                                rst_n,
  input  wire logic [cam_pkg::AXIL_ADDR_BITS-1:0]  awaddr,
  input  wire logic                                awvalid,
  output logic                                     awready,
  input  wire logic [cam_pkg::AXIL_DATA_BITS-1:0]  wdata,
  input  wire logic                                wvalid,
  output logic                                     wready,
  output logic [1:0]                               bresp,
  output logic                                     bvalid,
  input  wire logic                                bready,
  input  wire logic [cam_pkg::AXIL_ADDR_BITS-1:0]  araddr,
  input  wire logic                                arvalid,
  output logic                                     arready,
  output logic [cam_pkg::AXIL_DATA_BITS-1:0]       rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  wire logic                                rready,
  input  wire logic [cam_pkg::WORD_BITS-1:0]       head,
  input  wire logic [cam_pkg::STAT_COUNT_BITS-1:0] count,
  input  wire logic                                data_ready,
  input  wire logic                                overflow,
  input  wire logic                                frame_end,
  output logic                                     capture_en,
  output logic                                     clear,
  output logic                                     pop,
  output logic                                     sensor_reset_n
);

  localparam int DW = cam_pkg::AXIL_DATA_BITS;

  logic                                  ctrl_capture;
  logic                                  ctrl_sreset;
  logic [cam_pkg::STAT_FRAMES_BITS-1:0]  frame_cnt;
  logic                                  wr_accept;
  logic                                  wr_ctrl;
  logic                                  rd_accept;
  logic                                  buf_empty;
  logic [DW-1:0]                         ctrl_word;
  logic [DW-1:0]                         status_word;
  logic [DW-1:0]                         rd_mux;

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  assign wr_accept = awvalid & wvalid & ~bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign bresp     = cam_pkg::AXIL_RESP_OKAY;
  assign wr_ctrl   = wr_accept & (awaddr == cam_pkg::REG_CONTROL);

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      bvalid       <= 1'b0;
      ctrl_capture <= 1'b0;
      ctrl_sreset  <= 1'b0;
      clear        <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // Clear bit is a strobe and is never stored
      clear <= wr_ctrl & wdata[cam_pkg::CTRL_FIFO_CLEAR];
      if (wr_ctrl) begin
        ctrl_capture <= wdata[cam_pkg::CTRL_CAPTURE_EN];
        ctrl_sreset  <= wdata[cam_pkg::CTRL_SENSOR_RESET];
      end
    end
  end

  assign capture_en     = ctrl_capture;
  assign sensor_reset_n = ~ctrl_sreset;

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (frame_end) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  assign rd_accept = arvalid & ~rvalid;
  assign arready   = rd_accept;
  assign rresp     = cam_pkg::AXIL_RESP_OKAY;
  assign buf_empty = (count == '0);
  assign pop       = rd_accept & (araddr == cam_pkg::REG_DATA_HI) & ~buf_empty;

  always_comb begin
    ctrl_word = '0;
    ctrl_word[cam_pkg::CTRL_CAPTURE_EN]   = ctrl_capture;
    ctrl_word[cam_pkg::CTRL_SENSOR_RESET] = ctrl_sreset;

    status_word = '0;
    status_word[cam_pkg::STAT_COUNT_LSB +: cam_pkg::STAT_COUNT_BITS]   = count;
    status_word[cam_pkg::STAT_DATA_READY]                              = data_ready;
    status_word[cam_pkg::STAT_OVERFLOW]                                = overflow;
    status_word[cam_pkg::STAT_FRAMES_LSB +: cam_pkg::STAT_FRAMES_BITS] = frame_cnt;

    case (araddr)
      cam_pkg::REG_CONTROL: rd_mux = ctrl_word;
      cam_pkg::REG_STATUS:  rd_mux = status_word;
      cam_pkg::REG_DATA_LO: rd_mux = buf_empty ? '0 : head[DW-1:0];
      cam_pkg::REG_DATA_HI: rd_mux = buf_empty ? '0 : head[2*DW-1:DW];
      default:              rd_mux = '0;
    endcase
  end

  always_ff @(posedge pix_clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge pix_clk) begin
    if (rd_accept) begin
      rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* src/cam_capture_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_capture_top #(
  parameter int FIFO_DEPTH      = 512,
  parameter int READY_THRESHOLD = 256
) (
  input  wire logic                               pix_clk,
  input  wire logic                               rst_n,
  input  wire logic                               frame_valid,
  input  wire logic                               line_valid,
  input  wire logic [cam_pkg::PIX_BITS-1:0]       pix_data,
  input  wire logic [cam_pkg::AXIL_ADDR_BITS-1:0] s_axil_awaddr,
  input  wire logic                               s_axil_awvalid,
  output logic                                    s_axil_awready,
  input  wire logic [cam_pkg::AXIL_DATA_BITS-1:0] s_axil_wdata,
  input  wire logic                               s_axil_wvalid,
  output logic                                    s_axil_wready,
  output logic [1:0]                              s_axil_bresp,
  output logic                                    s_axil_bvalid,
  input  wire logic                               s_axil_bready,
  input  wire logic [cam_pkg::AXIL_ADDR_BITS-1:0] s_axil_araddr,
  input  wire logic                               s_axil_arvalid,
  output logic                                    s_axil_arready,
  output logic [cam_pkg::AXIL_DATA_BITS-1:0]      s_axil_rdata,
  output logic [1:0]                              s_axil_rresp,
  output logic                                    s_axil_rvalid,
  input  wire logic                               s_axil_rready,
  output logic                                    data_ready,
  output logic                                    sensor_reset_n
);

  logic                                capture_en;
  logic                                word_valid;
  cam_pkg::pix_word_u                  word;
  logic                                frame_end;
  logic                                pop;
  logic                                clear;
  logic [cam_pkg::WORD_BITS-1:0]       head;
  logic [cam_pkg::STAT_COUNT_BITS-1:0] count;
  logic                                overflow;

  pixel_stream_if pix_if ();

  // ------------------------------------------------------------
  // Sensor side
  // ------------------------------------------------------------
  pixel_capture pixel_capture_inst (
    .pix_clk     (pix_clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .line_valid  (line_valid),
    .pix_data    (pix_data),
    .capture_en  (capture_en),
    .out         (pix_if.source)
  );

  pixel_packer pixel_packer_inst (
    .pix_clk    (pix_clk),
    .rst_n      (rst_n),
    .in         (pix_if.sink),
    .word_valid (word_valid),
    .word       (word),
    .frame_end  (frame_end)
  );

  // ------------------------------------------------------------
  // Buffer and host side
  // ------------------------------------------------------------
  frame_fifo #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .READY_THRESHOLD (READY_THRESHOLD)
  ) frame_fifo_inst (
    .pix_clk    (pix_clk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .word       (word),
    .pop        (pop),
    .clear      (clear),
    .head       (head),
    .count      (count),
    .data_ready (data_ready),
    .overflow   (overflow)
  );

  axil_regs axil_regs_inst (
    .pix_clk        (pix_clk),
    .rst_n          (rst_n),
    .awaddr         (s_axil_awaddr),
    .awvalid        (s_axil_awvalid),
    .awready        (s_axil_awready),
    .wdata          (s_axil_wdata),
    .wvalid         (s_axil_wvalid),
    .wready         (s_axil_wready),
    .bresp          (s_axil_bresp),
    .bvalid         (s_axil_bvalid),
    .bready         (s_axil_bready),
    .araddr         (s_axil_araddr),
    .arvalid        (s_axil_arvalid),
    .arready        (s_axil_arready),
    .rdata          (s_axil_rdata),
    .rresp          (s_axil_rresp),
    .rvalid         (s_axil_rvalid),
    .rready         (s_axil_rready),
    .head           (head),
    .count          (count),
    .data_ready     (data_ready),
    .overflow       (overflow),
    .frame_end      (frame_end),
    .capture_en     (capture_en),
    .clear          (clear),
    .pop            (pop),
    .sensor_reset_n (sensor_reset_n)
  );

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// 8 ns pixel clock, reset held low for the first 8 cycles
module clk_gen (
  output logic pix_clk,
  output logic rst_n
);

  initial begin
    pix_clk = 1'b0;
    forever #4 pix_clk = ~pix_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge pix_clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/cam_capture_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_capture_properties #(
  parameter int FIFO_DEPTH = 512
) (
  input wire logic        pix_clk,
  input wire logic        rst_n,
  input wire logic [15:0] count,
  input wire logic        awvalid,
  input wire logic        awready,
  input wire logic        bvalid,
  input wire logic        bready,
  input wire logic        rvalid,
  input wire logic        rready,
  input wire logic [31:0] rdata
);

  // Buffer occupancy bound
  count_bound_a: assert property (@(posedge pix_clk) disable iff (!rst_n)
    count <= FIFO_DEPTH)
    else $error("word count above buffer depth");

  // ------------------------------------------------------------
  // AXI4-Lite response hold
  // ------------------------------------------------------------
  rvalid_hold_a: assert property (@(posedge pix_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response dropped or changed before rready");

  bvalid_hold_a: assert property (@(posedge pix_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("write response dropped before bready");

  awready_a: assert property (@(posedge pix_clk) disable iff (!rst_n)
    awready |-> awvalid)
    else $error("awready without awvalid");

endmodule

bind cam_capture_top cam_capture_properties #(
  .FIFO_DEPTH (FIFO_DEPTH)
) cam_capture_properties_inst (
  .pix_clk (pix_clk),
  .rst_n   (rst_n),
  .count   (count),
  .awvalid (s_axil_awvalid),
  .awready (s_axil_awready),
  .bvalid  (s_axil_bvalid),
  .bready  (s_axil_bready),
  .rvalid  (s_axil_rvalid),
  .rready  (s_axil_rready),
  .rdata   (s_axil_rdata)
);

`default_nettype wire

/* tests/tb_cam_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cam_capture;

  localparam int DEPTH     = 512;
  localparam int THRESHOLD = 256;
  localparam int NUM_ROWS  = 6;

  typedef struct {
    int lines;
    int ppl;
    int blank;
    bit cap_en;
    bit drain;
    bit clr;
  } row_t;

  logic        pix_clk;
  logic        rst_n;
  logic        frame_valid;
  logic        line_valid;
  logic [11:0] pix_data;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        data_ready;
  logic        sensor_reset_n;

  row_t        rows [NUM_ROWS];
  logic [63:0] model_q [$];
  logic        exp_overflow = 1'b0;
  int          exp_frames = 0;
  int          seed = 32'h0f833f95;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 1000000;

  clk_gen clk_gen_inst (
    .pix_clk (pix_clk),
    .rst_n   (rst_n)
  );

  cam_capture_top #(
    .FIFO_DEPTH      (DEPTH),
    .READY_THRESHOLD (THRESHOLD)
  ) cam_capture_top_inst (
    .pix_clk        (pix_clk),
    .rst_n          (rst_n),
    .frame_valid    (frame_valid),
    .line_valid     (line_valid),
    .pix_data       (pix_data),
    .s_axil_awaddr  (awaddr),
    .s_axil_awvalid (awvalid),
    .s_axil_awready (awready),
    .s_axil_wdata   (wdata),
    .s_axil_wvalid  (wvalid),
    .s_axil_wready  (wready),
    .s_axil_bresp   (bresp),
    .s_axil_bvalid  (bvalid),
    .s_axil_bready  (bready),
    .s_axil_araddr  (araddr),
    .s_axil_arvalid (arvalid),
    .s_axil_arready (arready),
    .s_axil_rdata   (rdata),
    .s_axil_rresp   (rresp),
    .s_axil_rvalid  (rvalid),
    .s_axil_rready  (rready),
    .data_ready     (data_ready),
    .sensor_reset_n (sensor_reset_n)
  );

  always @(posedge pix_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // Stimulus phase is 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge pix_clk);
    #1;
  endtask

  // ------------------------------------------------------------
  // Host accesses with random response stalls
  // ------------------------------------------------------------
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
    int stall;
    stall = $random(seed) & 3;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #2;
    check_value("awready", awready, 1'b1);
    check_value("wready", wready, 1'b1);
    next_cycle();
    while (!bvalid) next_cycle();
    // No second write while the response is pending
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_value("bresp", bresp, 2'b00);
    repeat (stall) begin
      next_cycle();
      check_value("bvalid", bvalid, 1'b1);
    end
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
    check_value("bvalid", bvalid, 1'b0);
    next_cycle();
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    int stall;
    stall = $random(seed) & 3;
    araddr  = addr;
    arvalid = 1'b1;
    #2;
    check_value("arready", arready, 1'b1);
    next_cycle();
    while (!rvalid) next_cycle();
    check_value("arready", arready, 1'b0);
    arvalid = 1'b0;
    data    = rdata;
    check_value("rresp", rresp, 2'b00);
    repeat (stall) begin
      next_cycle();
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, data);
    end
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
    check_value("rvalid", rvalid, 1'b0);
    next_cycle();
  endtask

  task automatic check_status();
    logic [31:0] st;
    axil_read(cam_pkg::REG_STATUS, st);
    check_value("status.count", st[15:0], model_q.size());
    check_value("status.data_ready", st[cam_pkg::STAT_DATA_READY],
                model_q.size() > THRESHOLD);
    check_value("status.overflow", st[cam_pkg::STAT_OVERFLOW], exp_overflow);
    check_value("status.frames", st[31:24], exp_frames[7:0]);
    check_value("data_ready", data_ready, model_q.size() > THRESHOLD);
  endtask

  // ------------------------------------------------------------
  // Sensor frame and packing model
  // ------------------------------------------------------------
  task automatic drive_frame(input row_t row);
    logic [11:0] pix_q [$];
    logic [63:0] w;
    int l;
    int p;
    int j;
    frame_valid = 1'b1;
    for (l = 0; l < row.lines; l++) begin
      line_valid = 1'b0;
      repeat (row.blank) next_cycle();
      for (p = 0; p < row.ppl; p++) begin
        line_valid = 1'b1;
        pix_data   = 12'($random(seed));
        pix_q.push_back(pix_data);
        next_cycle();
      end
    end
    line_valid = 1'b0;
    next_cycle();
    frame_valid = 1'b0;
    repeat (8) next_cycle();
    if (row.cap_en) begin
      exp_frames = exp_frames + 1;
      // Four 16-bit slots per word, slot 0 lowest, missing slots zero
      for (p = 0; p < pix_q.size(); p += 4) begin
        w = '0;
        for (j = 0; j < 4; j++) begin
          if (p + j < pix_q.size()) w[j*16 +: 16] = {4'h0, pix_q[p+j]};
        end
        if (model_q.size() < DEPTH) model_q.push_back(w);
        else exp_overflow = 1'b1;
      end
    end
  endtask

  task automatic drain_buffer();
    logic [63:0] exp;
    logic [31:0] lo;
    logic [31:0] hi;
    while (model_q.size() > 0) begin
      check_status();
      exp = model_q.pop_front();
      axil_read(cam_pkg::REG_DATA_LO, lo);
      check_value("data_lo", lo, exp[31:0]);
      axil_read(cam_pkg::REG_DATA_HI, hi);
      check_value("data_hi", hi, exp[63:32]);
    end
    check_status();
    axil_read(cam_pkg::REG_DATA_LO, lo);
    check_value("data_lo empty", lo, 32'h0);
    axil_read(cam_pkg::REG_DATA_HI, hi);
    check_value("data_hi empty", hi, 32'h0);
  endtask

  function automatic int compute_limit();
    int total;
    int words;
    int accesses;
    int r;
    total    = 20;
    accesses = 20;
    for (r = 0; r < NUM_ROWS; r++) begin
      total = total + rows[r].lines * (rows[r].ppl + rows[r].blank) + 20;
      words = rows[r].cap_en ? (rows[r].lines * rows[r].ppl + 3) / 4 : 0;
      if (words > DEPTH) words = DEPTH;
      accesses = accesses + 3 + (rows[r].drain ? 3 * words + 4 : 0);
      accesses = accesses + (rows[r].clr ? 3 : 0);
    end
    return total + accesses * 20 + 500;
  endfunction

  initial begin
    logic [31:0] rd;
    int r;
    frame_valid = 1'b0;
    line_valid  = 1'b0;
    pix_data    = '0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;

    // lines, pixels per line, blanking, capture, drain, clear
    rows[0] = '{2, 8, 4, 1'b1, 1'b1, 1'b0};
    rows[1] = '{3, 5, 3, 1'b1, 1'b1, 1'b0};
    rows[2] = '{1, 3, 6, 1'b1, 1'b1, 1'b0};
    rows[3] = '{20, 64, 2, 1'b1, 1'b1, 1'b0};
    rows[4] = '{1, 8, 5, 1'b0, 1'b1, 1'b0};
    rows[5] = '{40, 64, 2, 1'b1, 1'b0, 1'b1};
    cycle_limit = compute_limit();

    @(posedge rst_n);
    next_cycle();
    axil_read(cam_pkg::REG_STATUS, rd);
    check_value("status after reset", rd, 32'h0);
    check_value("sensor_reset_n", sensor_reset_n, 1'b1);
    check_value("data_ready", data_ready, 1'b0);

    for (r = 0; r < NUM_ROWS; r++) begin
      axil_write(cam_pkg::REG_CONTROL, 32'(rows[r].cap_en) << cam_pkg::CTRL_CAPTURE_EN);
      drive_frame(rows[r]);
      check_status();
      if (rows[r].drain) drain_buffer();
      if (rows[r].clr) begin
        axil_write(cam_pkg::REG_CONTROL, 32'h1 << cam_pkg::CTRL_FIFO_CLEAR);
        model_q.delete();
        exp_overflow = 1'b0;
        check_status();
        axil_read(cam_pkg::REG_CONTROL, rd);
        check_value("control after clear", rd, 32'h0);
      end
    end

    // Sensor reset bit and read-only status
    axil_write(cam_pkg::REG_CONTROL, 32'h1 << cam_pkg::CTRL_SENSOR_RESET);
    check_value("sensor_reset_n", sensor_reset_n, 1'b0);
    axil_read(cam_pkg::REG_CONTROL, rd);
    check_value("control", rd, 32'h1 << cam_pkg::CTRL_SENSOR_RESET);
    axil_write(cam_pkg::REG_CONTROL, 32'h0);
    check_value("sensor_reset_n", sensor_reset_n, 1'b1);
    axil_write(cam_pkg::REG_STATUS, 32'hffff_ffff);
    check_value("sensor_reset_n", sensor_reset_n, 1'b1);
    axil_read(cam_pkg::REG_CONTROL, rd);
    check_value("control after status write", rd, 32'h0);
    check_status();

    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
src/cam_pkg.sv
src/pixel_stream_if.sv
src/pixel_capture.sv
src/pixel_packer.sv
src/frame_fifo.sv
src/axil_regs.sv
src/cam_capture_top.sv
tests/clk_gen.sv
tests/cam_capture_properties.sv
tests/tb_cam_capture.sv
